// File: sniff_macros.svh
// Register addresses, field widths, FIFO sizing and FIFO command codes of the sniffer
`ifndef SNIFF_MACROS_SVH
`define SNIFF_MACROS_SVH

//////////////////////////////////////////////////////////////////////////////
// Register map
//////////////////////////////////////////////////////////////////////////////
`define SNIFF_REG_ARM            6'h10
`define SNIFF_REG_TS_DISABLE     6'h11
`define SNIFF_REG_CAPTURE_LEN    6'h12
`define SNIFF_REG_TRIGGER_DELAY  6'h13
`define SNIFF_REG_FIFO_STAT      6'h14
`define SNIFF_REG_FIFO_RD        6'h15

//////////////////////////////////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////////////////////////////////
`define SNIFF_ADDR_W        6
`define SNIFF_BYTECNT_W     7
`define SNIFF_TIME_W        16
`define SNIFF_SHORT_TIME_W  3
`define SNIFF_STAT_W        5
`define SNIFF_CMD_W         2
`define SNIFF_CAPLEN_W      16
`define SNIFF_TRIGDLY_W     20

// Capture FIFO size and the fill level where new events are refused
`define SNIFF_FIFO_DEPTH    16
`define SNIFF_FIFO_THRESH   14

// FIFO entry command codes
`define SNIFF_CMD_DATA      2'b00
`define SNIFF_CMD_STAT      2'b01
`define SNIFF_CMD_TIME      2'b10
`define SNIFF_CMD_STRM      2'b11

// Data field of the marker returned when the host reads an empty FIFO
`define SNIFF_STRM_EMPTY    8'hE5

`endif

// File: sniff_pkg.sv
// Register bus, capture event, FIFO entry and FIFO status types of the sniffer
`include "sniff_macros.svh"

package sniff_pkg;

   // Host register access, one byte per strobe
   typedef struct packed {
      logic [`SNIFF_ADDR_W-1:0]    address;
      logic [`SNIFF_BYTECNT_W-1:0] bytecnt;
      logic [7:0]                  write_data;
      logic                        read;
      logic                        write;
      logic                        addrvalid;
   } reg_bus_t;

   // One event from the USB front end
   typedef struct packed {
      logic [`SNIFF_TIME_W-1:0] tstamp;
      logic [7:0]               data;
      logic [`SNIFF_STAT_W-1:0] stat;
      logic [`SNIFF_CMD_W-1:0]  cmd;
   } capture_t;

   // DATA, STAT and STRM entries
   typedef struct packed {
      logic [`SNIFF_CMD_W-1:0]        cmd;
      logic [`SNIFF_SHORT_TIME_W-1:0] short_time;
      logic [`SNIFF_STAT_W-1:0]       stat;
      logic [7:0]                     data;
   } fe_event_t;

   // TIME entries carry the whole timestamp
   typedef struct packed {
      logic [`SNIFF_CMD_W-1:0]  cmd;
      logic [`SNIFF_TIME_W-1:0] tstamp;
   } fe_time_t;

   // 18-bit FIFO word, decoded by its command field
   typedef union packed {
      fe_event_t ev;
      fe_time_t  ts;
   } fe_entry_t;

   // Zero-extended this gives the FIFO status byte, empty in bit 0
   typedef struct packed {
      logic overflow_blocked;
      logic almost_full;
      logic empty;
   } fifo_status_t;

endpackage

// File: sniff_reg_file.sv
// Capture configuration registers, arm control and the registered read-back byte
`include "sniff_macros.svh"

module sniff_reg_file (
   input  logic                         cwusb_clk,
   input  logic                         reset_i,
   input  sniff_pkg::reg_bus_t          host_bus,
   input  logic                         match,
   input  sniff_pkg::fifo_status_t      status,
   output logic                         arm_req,
   output logic                         timestamps_disable,
   output logic [`SNIFF_CAPLEN_W-1:0]   capture_len,
   output logic [`SNIFF_TRIGDLY_W-1:0]  trigger_delay,
   output logic [7:0]                   reg_rdata
);

   logic        write_strobe;
   logic        read_strobe;
   logic        lane_ok;
   logic [1:0]  lane;
   logic [31:0] cap_word;
   logic [31:0] trig_word;
   logic [31:0] cap_merged;
   logic [31:0] trig_merged;
   logic [7:0]  status_byte;

   // Replace one byte lane of a register word
   function automatic logic [31:0] merge_lane(input logic [31:0] word,
                                              input logic [1:0]  sel,
                                              input logic [7:0]  data);
      logic [31:0] result;
      result = word;
      result[{sel, 3'b000} +: 8] = data;
      return result;
   endfunction

   assign write_strobe = host_bus.addrvalid & host_bus.write;
   assign read_strobe  = host_bus.addrvalid & host_bus.read;

   // Multi-byte registers only have lanes 0 to 3
   assign lane    = host_bus.bytecnt[1:0];
   assign lane_ok = (host_bus.bytecnt[`SNIFF_BYTECNT_W-1:2] == '0);

   assign cap_word  = {{(32-`SNIFF_CAPLEN_W){1'b0}}, capture_len};
   assign trig_word = {{(32-`SNIFF_TRIGDLY_W){1'b0}}, trigger_delay};

   assign cap_merged  = merge_lane(cap_word, lane, host_bus.write_data);
   assign trig_merged = merge_lane(trig_word, lane, host_bus.write_data);

   assign status_byte = {{(8-$bits(status)){1'b0}}, status};

   //////////////////////////////////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm_req            <= 1'b0;
         timestamps_disable <= 1'b0;
         capture_len        <= '0;
         trigger_delay      <= '0;
      end else begin
         // A host write wins over a match in the same cycle
         if (write_strobe && (host_bus.address == `SNIFF_REG_ARM))
            arm_req <= host_bus.write_data[0];
         else if (match)
            arm_req <= 1'b0;

         if (write_strobe) begin
            case (host_bus.address)
               `SNIFF_REG_TS_DISABLE:
                  timestamps_disable <= host_bus.write_data[0];
               `SNIFF_REG_CAPTURE_LEN:
                  if (lane_ok)
                     capture_len <= cap_merged[`SNIFF_CAPLEN_W-1:0];
               `SNIFF_REG_TRIGGER_DELAY:
                  if (lane_ok)
                     trigger_delay <= trig_merged[`SNIFF_TRIGDLY_W-1:0];
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // Read-back, held until the next read strobe
   //////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         reg_rdata <= 8'h00;
      end else if (read_strobe) begin
         case (host_bus.address)
            `SNIFF_REG_ARM:
               reg_rdata <= {7'b0, arm_req};
            `SNIFF_REG_TS_DISABLE:
               reg_rdata <= {7'b0, timestamps_disable};
            `SNIFF_REG_CAPTURE_LEN:
               reg_rdata <= lane_ok ? cap_word[{lane, 3'b000} +: 8] : 8'h00;
            `SNIFF_REG_TRIGGER_DELAY:
               reg_rdata <= lane_ok ? trig_word[{lane, 3'b000} +: 8] : 8'h00;
            // FIFO reads also pick the status up here for their third byte
            `SNIFF_REG_FIFO_STAT, `SNIFF_REG_FIFO_RD:
               reg_rdata <= status_byte;
            default:
               reg_rdata <= 8'h00;
         endcase
      end
   end

endmodule

// File: sniff_entry_packer.sv
// Capture event to FIFO entry packing, threshold drop and overflow sticky bit
`include "sniff_macros.svh"

module sniff_entry_packer (
   input  logic                 cwusb_clk,
   input  logic                 reset_i,
   input  sniff_pkg::capture_t  capture,
   input  logic                 capture_wr,
   input  logic                 almost_full,
   input  logic                 arm_req,
   output logic                 wr_en,
   output sniff_pkg::fe_entry_t wr_entry,
   output logic                 overflow_blocked
);

   import sniff_pkg::*;

   fe_entry_t next_entry;
   logic      accept;

   // No back-pressure, so an event past the threshold is lost
   assign accept = capture_wr & ~almost_full;

   // Entry layout follows the command
   always_comb begin
      next_entry = '0;
      if (capture.cmd == `SNIFF_CMD_TIME) begin
         next_entry.ts.cmd    = capture.cmd;
         next_entry.ts.tstamp = capture.tstamp;
      end else begin
         next_entry.ev.cmd        = capture.cmd;
         next_entry.ev.short_time = capture.tstamp[`SNIFF_SHORT_TIME_W-1:0];
         next_entry.ev.stat       = capture.stat;
         // STAT entries have an empty data field
         if (capture.cmd == `SNIFF_CMD_DATA)
            next_entry.ev.data = capture.data;
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_en            <= 1'b0;
         overflow_blocked <= 1'b0;
      end else begin
         wr_en <= accept;

         // Sticky until the next arm
         if (capture_wr && almost_full)
            overflow_blocked <= 1'b1;
         else if (arm_req)
            overflow_blocked <= 1'b0;
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (accept)
         wr_entry <= next_entry;
   end

endmodule

// File: sniff_fifo.sv
// Synchronous capture FIFO with occupancy count, empty and almost-full flags
`include "sniff_macros.svh"

module sniff_fifo (
   input  logic                 cwusb_clk,
   input  logic                 reset_i,
   input  logic                 wr_en,
   input  sniff_pkg::fe_entry_t wr_entry,
   input  logic                 rd_en,
   output sniff_pkg::fe_entry_t head,
   output logic                 empty,
   output logic                 almost_full
);

   import sniff_pkg::*;

   localparam int DEPTH = `SNIFF_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);
   localparam logic [CNT_W:0]   THRESH     = (CNT_W + 1)'(`SNIFF_FIFO_THRESH);

   fe_entry_t        mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic [CNT_W:0]   fill_pending;
   logic             do_write;
   logic             do_read;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
   endfunction

   assign do_write = wr_en & (count != FULL_COUNT);
   assign do_read  = rd_en & (count != '0);

   always_ff @(posedge cwusb_clk) begin
      if (do_write)
         mem[wr_ptr] <= wr_entry;
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_read)
            rd_ptr <= next_ptr(rd_ptr);

         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // First-word fall-through head
   assign head  = mem[rd_ptr];
   assign empty = (count == '0);

   // Counting the write still in flight keeps the accepted total at the threshold
   assign fill_pending = {1'b0, count} + {{CNT_W{1'b0}}, wr_en};
   assign almost_full  = (fill_pending >= THRESH);

endmodule

// File: sniff_fifo_reader.sv
// Byte-framed FIFO reads, empty marker, arm flush and the host read-data mux
`include "sniff_macros.svh"

module sniff_fifo_reader (
   input  logic                 cwusb_clk,
   input  logic                 reset_i,
   input  sniff_pkg::reg_bus_t  host_bus,
   input  sniff_pkg::fe_entry_t head,
   input  logic                 empty,
   input  logic                 arm_req,
   input  logic [7:0]           reg_rdata,
   output logic                 rd_en,
   output logic                 arm_out,
   output logic [7:0]           read_data
);

   import sniff_pkg::*;

   fe_entry_t  entry_q;
   fe_entry_t  marker;
   logic       read_strobe;
   logic       fifo_addr;
   logic       frame_start;
   logic       read_pop;
   logic       flush_pop;
   logic       arm_r;
   logic       flushing;
   logic       sel_fifo;
   logic [1:0] sel_byte;

   assign read_strobe = host_bus.addrvalid & host_bus.read;
   assign fifo_addr   = (host_bus.address == `SNIFF_REG_FIFO_RD);

   // Byte 0 of each four-byte frame takes the head entry
   assign frame_start = read_strobe & fifo_addr & (host_bus.bytecnt[1:0] == 2'd0);
   assign read_pop    = frame_start & ~empty;
   assign flush_pop   = flushing & ~empty;
   assign rd_en       = read_pop | flush_pop;

   always_comb begin
      marker         = '0;
      marker.ev.cmd  = `SNIFF_CMD_STRM;
      marker.ev.data = `SNIFF_STRM_EMPTY;
   end

   // Empty reads latch the marker and leave the FIFO alone
   always_ff @(posedge cwusb_clk) begin
      if (frame_start)
         entry_q <= empty ? marker : head;
   end

   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         sel_fifo <= 1'b0;
         sel_byte <= 2'd0;
      end else if (read_strobe) begin
         sel_fifo <= fifo_addr;
         sel_byte <= host_bus.bytecnt[1:0];
      end
   end

   //////////////////////////////////////////////////////////////////////////////
   // Arm flush
   //////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge cwusb_clk) begin
      if (reset_i) begin
         arm_r    <= 1'b0;
         flushing <= 1'b0;
      end else begin
         arm_r <= arm_req;
         if (arm_req && !arm_r)
            flushing <= 1'b1;
         else if (empty)
            flushing <= 1'b0;
      end
   end

   // Held low until the old entries are gone
   assign arm_out = arm_r & ~flushing;

   //////////////////////////////////////////////////////////////////////////////
   // Read data mux
   //////////////////////////////////////////////////////////////////////////////
   always_comb begin
      if (sel_fifo) begin
         case (sel_byte)
            2'd0:    read_data = entry_q[7:0];
            2'd1:    read_data = entry_q[15:8];
            // Status byte from the register file sits above the command bits
            2'd2:    read_data = {reg_rdata[5:0], entry_q[17:16]};
            default: read_data = 8'h00;
         endcase
      end else begin
         read_data = reg_rdata;
      end
   end

endmodule

// File: sniff_top.sv
// Sniffer register and capture-buffer top level with its four submodules
`include "sniff_macros.svh"

module sniff_top (
   input  logic                         cwusb_clk,
   input  logic                         reset_i,
   input  sniff_pkg::reg_bus_t          host_bus,
   output logic [7:0]                   read_data,
   input  sniff_pkg::capture_t          capture,
   input  logic                         capture_wr,
   input  logic                         match,
   output logic                         arm_out,
   output logic                         timestamps_disable,
   output logic [`SNIFF_CAPLEN_W-1:0]   capture_len,
   output logic [`SNIFF_TRIGDLY_W-1:0]  trigger_delay
);

   import sniff_pkg::*;

   logic         arm_req;
   logic [7:0]   reg_rdata;
   logic         wr_en;
   logic         rd_en;
   fe_entry_t    wr_entry;
   fe_entry_t    head;
   logic         fifo_empty;
   logic         fifo_almost_full;
   logic         overflow_blocked;
   fifo_status_t fifo_status;

   assign fifo_status.empty            = fifo_empty;
   assign fifo_status.almost_full      = fifo_almost_full;
   assign fifo_status.overflow_blocked = overflow_blocked;

   sniff_reg_file i_reg_file (
      .cwusb_clk          (cwusb_clk),
      .reset_i            (reset_i),
      .host_bus           (host_bus),
      .match              (match),
      .status             (fifo_status),
      .arm_req            (arm_req),
      .timestamps_disable (timestamps_disable),
      .capture_len        (capture_len),
      .trigger_delay      (trigger_delay),
      .reg_rdata          (reg_rdata)
   );

   sniff_entry_packer i_packer (
      .cwusb_clk        (cwusb_clk),
      .reset_i          (reset_i),
      .capture          (capture),
      .capture_wr       (capture_wr),
      .almost_full      (fifo_almost_full),
      .arm_req          (arm_req),
      .wr_en            (wr_en),
      .wr_entry         (wr_entry),
      .overflow_blocked (overflow_blocked)
   );

   sniff_fifo i_fifo (
      .cwusb_clk   (cwusb_clk),
      .reset_i     (reset_i),
      .wr_en       (wr_en),
      .wr_entry    (wr_entry),
      .rd_en       (rd_en),
      .head        (head),
      .empty       (fifo_empty),
      .almost_full (fifo_almost_full)
   );

   sniff_fifo_reader i_reader (
      .cwusb_clk (cwusb_clk),
      .reset_i   (reset_i),
      .host_bus  (host_bus),
      .head      (head),
      .empty     (fifo_empty),
      .arm_req   (arm_req),
      .reg_rdata (reg_rdata),
      .rd_en     (rd_en),
      .arm_out   (arm_out),
      .read_data (read_data)
   );

endmodule

// File: tb_sniff.sv
// Testbench for the sniffer top level with clock, reset, random stimulus, FIFO model and checks
`include "sniff_macros.svh"

module tb_sniff;

   timeunit 1ns;
   timeprecision 100ps;

   import sniff_pkg::*;

   localparam int RESET_CYCLES  = 8;
   localparam int CFG_ROUNDS    = 4;
   localparam int PACK_EVENTS   = 10;
   localparam int OVF_EVENTS    = 20;
   localparam int ARM_FILL      = 5;
   localparam int ARM_WAIT_MAX  = 2 * `SNIFF_FIFO_DEPTH + 8;

   // Bus accesses and capture strobes take two cycles each, a frame is four accesses
   localparam int ACCESS_CYCLES = 2;
   localparam int FRAME_CYCLES  = 4 * ACCESS_CYCLES;
   localparam int CFG_CYCLES    = CFG_ROUNDS * 13 * ACCESS_CYCLES + 4;
   localparam int PACK_CYCLES   = PACK_EVENTS * (ACCESS_CYCLES + FRAME_CYCLES) + 4;
   localparam int EMPTY_CYCLES  = FRAME_CYCLES;
   localparam int OVF_CYCLES    = OVF_EVENTS * ACCESS_CYCLES
                                  + (`SNIFF_FIFO_THRESH + 1) * FRAME_CYCLES + ACCESS_CYCLES + 4;
   localparam int ARM_CYCLES    = ARM_FILL * ACCESS_CYCLES + ARM_WAIT_MAX
                                  + 3 * ACCESS_CYCLES + 8;
   localparam int RUN_LIMIT     = 2 * (RESET_CYCLES + CFG_CYCLES + PACK_CYCLES + EMPTY_CYCLES
                                       + OVF_CYCLES + ARM_CYCLES);

   logic                        cwusb_clk;
   logic                        reset_i;
   reg_bus_t                    host_bus;
   logic [7:0]                  read_data;
   capture_t                    capture;
   logic                        capture_wr;
   logic                        match;
   logic                        arm_out;
   logic                        timestamps_disable;
   logic [`SNIFF_CAPLEN_W-1:0]  capture_len;
   logic [`SNIFF_TRIGDLY_W-1:0] trigger_delay;

   // Reference model state
   logic [17:0]                 fifo_q[$];
   logic                        model_ovf;
   logic                        model_ts;
   logic [`SNIFF_CAPLEN_W-1:0]  model_cap;
   logic [`SNIFF_TRIGDLY_W-1:0] model_trig;

   int    seed;
   int    cycle_count;
   int    check_count;
   int    error_count;
   int    test_count;
   int    test_checks;
   int    test_errors;
   string test_name;

   sniff_top i_dut (
      .cwusb_clk          (cwusb_clk),
      .reset_i            (reset_i),
      .host_bus           (host_bus),
      .read_data          (read_data),
      .capture            (capture),
      .capture_wr         (capture_wr),
      .match              (match),
      .arm_out            (arm_out),
      .timestamps_disable (timestamps_disable),
      .capture_len        (capture_len),
      .trigger_delay      (trigger_delay)
   );

   initial begin
      cwusb_clk = 1'b0;
      forever #2 cwusb_clk = ~cwusb_clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < RUN_LIMIT) begin
         @(posedge cwusb_clk);
         cycle_count++;
      end
      $display("timeout: the run was still busy after %0d cycles", RUN_LIMIT);
      $display("Simulation failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and model helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   // Mix of DATA, STAT and TIME events
   function automatic capture_t random_event();
      capture_t    ev;
      logic [31:0] r;
      r         = $random(seed);
      ev.tstamp = r[15:0];
      ev.data   = r[23:16];
      ev.stat   = r[28:24];
      r         = $random(seed);
      case (r % 3)
         0:       ev.cmd = `SNIFF_CMD_DATA;
         1:       ev.cmd = `SNIFF_CMD_STAT;
         default: ev.cmd = `SNIFF_CMD_TIME;
      endcase
      return ev;
   endfunction

   // TIME keeps the whole stamp, the others only its low three bits
   function automatic logic [17:0] expected_entry(input capture_t ev);
      logic [17:0] e;
      if (ev.cmd == `SNIFF_CMD_TIME)
         e = {ev.cmd, ev.tstamp};
      else if (ev.cmd == `SNIFF_CMD_DATA)
         e = {ev.cmd, ev.tstamp[2:0], ev.stat, ev.data};
      else
         e = {ev.cmd, ev.tstamp[2:0], ev.stat, 8'h00};
      return e;
   endfunction

   // Status byte: empty in bit 0, almost_full in bit 1, overflow in bit 2
   function automatic logic [7:0] expected_status();
      return {5'b0, model_ovf, fifo_q.size() >= `SNIFF_FIFO_THRESH, fifo_q.size() == 0};
   endfunction

   task automatic bus_write(input logic [`SNIFF_ADDR_W-1:0]    addr,
                            input logic [`SNIFF_BYTECNT_W-1:0] bcnt,
                            input logic [7:0]                  wdata);
      reg_bus_t req;
      req            = '0;
      req.address    = addr;
      req.bytecnt    = bcnt;
      req.write_data = wdata;
      req.write      = 1'b1;
      req.addrvalid  = 1'b1;
      @(posedge cwusb_clk);
      host_bus <= req;
      @(posedge cwusb_clk);
      host_bus <= '0;
   endtask

   task automatic bus_read(input  logic [`SNIFF_ADDR_W-1:0]    addr,
                           input  logic [`SNIFF_BYTECNT_W-1:0] bcnt,
                           output logic [7:0]                  data);
      reg_bus_t req;
      req           = '0;
      req.address   = addr;
      req.bytecnt   = bcnt;
      req.read      = 1'b1;
      req.addrvalid = 1'b1;
      @(posedge cwusb_clk);
      host_bus <= req;
      @(posedge cwusb_clk);
      host_bus <= '0;
      // Read data is settled away from the edge
      @(negedge cwusb_clk);
      data = read_data;
   endtask

   task automatic send_capture(input capture_t ev);
      @(posedge cwusb_clk);
      capture    <= ev;
      capture_wr <= 1'b1;
      @(posedge cwusb_clk);
      capture_wr <= 1'b0;
      // Accepted entries count from the strobe on
      if (fifo_q.size() < `SNIFF_FIFO_THRESH)
         fifo_q.push_back(expected_entry(ev));
      else
         model_ovf = 1'b1;
   endtask

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      check_count++;
      if (act !== exp) begin
         error_count++;
         $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
      end
   endtask

   // One four-byte frame from FIFO_RD against the model head or the empty marker
   task automatic check_frame(input int idx);
      logic [17:0] e;
      logic [7:0]  b;
      logic [7:0]  st;
      logic [31:0] exp_frame;
      logic [31:0] act_frame;
      int          i;
      if (fifo_q.size() > 0)
         e = fifo_q.pop_front();
      else
         e = {`SNIFF_CMD_STRM, 8'h00, `SNIFF_STRM_EMPTY};
      st        = expected_status();
      exp_frame = {8'h00, st[5:0], e[17:16], e[15:8], e[7:0]};
      act_frame = '0;
      for (i = 0; i < 4; i++) begin
         bus_read(`SNIFF_REG_FIFO_RD, 7'(i), b);
         act_frame[i*8 +: 8] = b;
      end
      check_value($sformatf("frame %0d", idx), exp_frame, act_frame);
   endtask

   task automatic begin_test(input string name);
      test_name   = name;
      test_checks = check_count;
      test_errors = error_count;
   endtask

   task automatic end_test();
      test_count++;
      $display("test %s finished: %0d checks, %0d errors", test_name,
               check_count - test_checks, error_count - test_errors);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_config_test();
      logic [7:0]  d;
      logic [31:0] cap_word;
      logic [31:0] trig_word;
      int          lane;
      int          round;
      begin_test("config_readback");
      @(negedge cwusb_clk);
      check_value("arm_out after reset", 0, arm_out);
      check_value("read_data after reset", 0, read_data);
      check_value("timestamps_disable after reset", 0, timestamps_disable);
      check_value("capture_len after reset", 0, capture_len);
      check_value("trigger_delay after reset", 0, trigger_delay);
      for (round = 0; round < CFG_ROUNDS; round++) begin
         d = rand_byte();
         bus_write(`SNIFF_REG_TS_DISABLE, 7'd0, d);
         model_ts = d[0];
         for (lane = 0; lane < 2; lane++) begin
            d = rand_byte();
            bus_write(`SNIFF_REG_CAPTURE_LEN, 7'(lane), d);
            model_cap[lane*8 +: 8] = d;
         end
         for (lane = 0; lane < 3; lane++) begin
            d = rand_byte();
            bus_write(`SNIFF_REG_TRIGGER_DELAY, 7'(lane), d);
            // Top lane holds only the four upper delay bits
            if (lane < 2)
               model_trig[lane*8 +: 8] = d;
            else
               model_trig[19:16] = d[3:0];
         end
         @(negedge cwusb_clk);
         check_value("timestamps_disable", model_ts, timestamps_disable);
         check_value("capture_len", model_cap, capture_len);
         check_value("trigger_delay", model_trig, trigger_delay);
         bus_read(`SNIFF_REG_TS_DISABLE, 7'd0, d);
         check_value("ts_disable read", {7'b0, model_ts}, d);
         cap_word  = {16'h0000, model_cap};
         trig_word = {12'h000, model_trig};
         for (lane = 0; lane < 3; lane++) begin
            bus_read(`SNIFF_REG_CAPTURE_LEN, 7'(lane), d);
            check_value($sformatf("capture_len byte %0d", lane), cap_word[lane*8 +: 8], d);
            bus_read(`SNIFF_REG_TRIGGER_DELAY, 7'(lane), d);
            check_value($sformatf("trigger_delay byte %0d", lane), trig_word[lane*8 +: 8], d);
         end
      end
      end_test();
   endtask

   task automatic run_pack_test();
      int i;
      begin_test("capture_packing");
      for (i = 0; i < PACK_EVENTS; i++)
         send_capture(random_event());
      // Last entry reaches the FIFO two cycles after its strobe
      repeat (2) @(posedge cwusb_clk);
      for (i = 0; i < PACK_EVENTS; i++)
         check_frame(i);
      end_test();
   endtask

   task automatic run_empty_test();
      begin_test("empty_read");
      check_frame(0);
      end_test();
   endtask

   task automatic run_overflow_test();
      logic [7:0] d;
      int         i;
      begin_test("overflow");
      for (i = 0; i < OVF_EVENTS; i++)
         send_capture(random_event());
      repeat (2) @(posedge cwusb_clk);
      bus_read(`SNIFF_REG_FIFO_STAT, 7'd0, d);
      check_value("fifo_stat after overflow", expected_status(), d);
      check_value("almost_full and overflow bits", 2'b11, d[2:1]);
      for (i = 0; i < `SNIFF_FIFO_THRESH; i++)
         check_frame(i);
      // Nothing past the threshold may remain
      check_frame(`SNIFF_FIFO_THRESH);
      end_test();
   endtask

   task automatic run_arm_test();
      logic [7:0] d;
      int         i;
      int         waited;
      begin_test("arm_flush_match");
      for (i = 0; i < ARM_FILL; i++)
         send_capture(random_event());
      repeat (2) @(posedge cwusb_clk);
      bus_write(`SNIFF_REG_ARM, 7'd0, 8'h01);
      // Arming flushes the FIFO and clears the overflow bit
      fifo_q.delete();
      model_ovf = 1'b0;
      waited    = 0;
      @(negedge cwusb_clk);
      while (!arm_out && waited < ARM_WAIT_MAX) begin
         @(negedge cwusb_clk);
         waited++;
      end
      check_count++;
      if (!arm_out) begin
         error_count++;
         $display("error %s: arm_out never rose after the arm write", test_name);
      end
      bus_read(`SNIFF_REG_FIFO_STAT, 7'd0, d);
      check_value("fifo_stat after arm", expected_status(), d);
      bus_read(`SNIFF_REG_ARM, 7'd0, d);
      check_value("arm read", 8'h01, d);
      @(posedge cwusb_clk);
      match <= 1'b1;
      @(posedge cwusb_clk);
      match <= 1'b0;
      @(negedge cwusb_clk);
      check_value("arm_out one cycle after match", 1, arm_out);
      @(negedge cwusb_clk);
      check_value("arm_out two cycles after match", 0, arm_out);
      end_test();
   endtask

   initial begin
      seed        = 97;
      check_count = 0;
      error_count = 0;
      test_count  = 0;
      host_bus    = '0;
      capture     = '0;
      capture_wr  = 1'b0;
      match       = 1'b0;
      reset_i     = 1'b1;
      model_ovf   = 1'b0;
      model_ts    = 1'b0;
      model_cap   = '0;
      model_trig  = '0;
      fifo_q.delete();
      repeat (RESET_CYCLES) @(posedge cwusb_clk);
      reset_i <= 1'b0;

      run_config_test();
      run_pack_test();
      run_empty_test();
      run_overflow_test();
      run_arm_test();

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
      if (error_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: build.f
+incdir+.
sniff_pkg.sv
sniff_reg_file.sv
sniff_entry_packer.sv
sniff_fifo.sv
sniff_fifo_reader.sv
sniff_top.sv
tb_sniff.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sniffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
   --top-module tb_sniff -f build.f -o sim_sniff
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_sniff)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
